// File: Bender.yml
package:
  name: n64_glue

sources:
  - design/n64_glue_pkg.sv
  - design/word_packer.sv
  - design/download_router.sv
  - design/aspect_ratio.sv
  - design/snac_port_mux.sv
  - design/n64_glue_top.sv
  - target: simulation
    files:
      - verification/n64_glue_asserts.sv
      - verification/n64_glue_tb.sv

// File: design/aspect_ratio.sv
//==================================================
// Video aspect ratio for the scaler, from the
// PAL/NTSC setting, vertical crop and aspect mode
//==================================================
`default_nettype none

module aspect_ratio (
	input  logic                     clk_1x,
	input  logic                     rst_n,
	input  n64_glue_pkg::video_cfg_t video_cfg,
	output logic [12:0]              video_arx,
	output logic [12:0]              video_ary
);

	n64_glue_pkg::ar_t core_x;
	n64_glue_pkg::ar_t core_y;

	// Core ratio, crop 3 has no table entry
	always_ff @(posedge clk_1x or negedge rst_n) begin
		if (!rst_n) begin
			core_x <= n64_glue_pkg::AR_DEFAULT_X;
			core_y <= n64_glue_pkg::AR_DEFAULT_Y;
		end else if (video_cfg.blanks_off) begin
			core_x <= n64_glue_pkg::AR_DEFAULT_X;
			core_y <= n64_glue_pkg::AR_DEFAULT_Y;
		end else if (video_cfg.crop != 2'd3) begin
			if (video_cfg.pal) begin
				core_x <= n64_glue_pkg::AR_PAL_X[video_cfg.crop];
				core_y <= n64_glue_pkg::AR_PAL_Y[video_cfg.crop];
			end else begin
				core_x <= n64_glue_pkg::AR_NTSC_X[video_cfg.crop];
				core_y <= n64_glue_pkg::AR_NTSC_Y[video_cfg.crop];
			end
		end
	end

	// Mode 0 is the core ratio, others pass a scaler preset on X
	always_comb begin
		if (video_cfg.ar_mode == 2'd0) begin
			video_arx = {1'b0, core_x};
			video_ary = {1'b0, core_y};
		end else begin
			video_arx = {11'd0, video_cfg.ar_mode - 2'd1};
			video_ary = 13'd0;
		end
	end

endmodule

`default_nettype wire

// File: design/download_router.sv
//==================================================
// Routes loader writes to the boot ROM or SDRAM
// packer and tracks the N64 cart download state
//==================================================
`default_nettype none

module download_router (
	input  logic                          clk_1x,
	input  logic                          rst_n,
	input  n64_glue_pkg::ioctl_t          ioctl,
	input  logic                          ram_ready,
	output logic                          ioctl_wait,
	output n64_glue_pkg::pif_wr_t         pif_wr,
	output n64_glue_pkg::ram_wr_t         ram_wr,
	output logic                          romcopy_start,
	output n64_glue_pkg::loader_addr_t    romcopy_size,
	output logic                          cart_loaded,
	output logic                          cart_busy
);

	logic [n64_glue_pkg::IDX_FIELD_W-1:0] idx;
	logic                                 pif_dl;
	logic                                 n64_dl;
	logic                                 gb_dl;
	logic                                 download_prev;
	logic                                 rom_end;
	n64_glue_pkg::pif_addr_t              pif_addr_in;
	n64_glue_pkg::pif_addr_t              pif_addr;
	n64_glue_pkg::word_t                  pif_data;
	logic                                 pif_wren;
	n64_glue_pkg::loader_addr_t           gb_addr_in;
	n64_glue_pkg::loader_addr_t           ram_addr;
	n64_glue_pkg::word_t                  ram_data;
	logic                                 ram_req;

	assign idx     = ioctl.index[n64_glue_pkg::IDX_FIELD_W-1:0];
	assign rom_end = !ioctl.download && download_prev && (idx == n64_glue_pkg::IDX_CART_N64);

	//==================================================
	// Download flags, ROM copy trigger, wait level
	//==================================================
	always_ff @(posedge clk_1x or negedge rst_n) begin
		if (!rst_n) begin
			pif_dl        <= 1'b0;
			n64_dl        <= 1'b0;
			gb_dl         <= 1'b0;
			download_prev <= 1'b0;
			romcopy_start <= 1'b0;
			cart_loaded   <= 1'b0;
			ioctl_wait    <= 1'b0;
		end else begin
			pif_dl        <= ioctl.download & (idx == n64_glue_pkg::IDX_PIFROM);
			n64_dl        <= ioctl.download & (idx == n64_glue_pkg::IDX_CART_N64);
			gb_dl         <= ioctl.download & (idx == n64_glue_pkg::IDX_CART_GB);
			download_prev <= ioctl.download;
			romcopy_start <= rom_end;
			if (n64_dl) begin
				cart_loaded <= 1'b1;
			end
			// Hold the loader until SDRAM takes the word
			if (!gb_dl || ram_ready) begin
				ioctl_wait <= 1'b0;
			end else if (ioctl.wr && ioctl.addr[1]) begin
				ioctl_wait <= 1'b1;
			end
		end
	end

	// Final loader address is the ROM size
	always_ff @(posedge clk_1x) begin
		if (rom_end) begin
			romcopy_size <= ioctl.addr;
		end
	end

	assign cart_busy = n64_dl | gb_dl;

	//==================================================
	// Word packers
	//==================================================
	assign pif_addr_in = {ioctl.index[6], ioctl.addr[10:2]};
	assign gb_addr_in  = ioctl.addr + n64_glue_pkg::CARTGB_START;

	word_packer #(
		.addr_t     (n64_glue_pkg::pif_addr_t),
		.swap_bytes (1'b1)
	) pif_packer (
		.clk_1x      (clk_1x),
		.rst_n       (rst_n),
		.enable      (pif_dl),
		.wr          (ioctl.wr),
		.half_sel    (ioctl.addr[1]),
		.half        (ioctl.dout),
		.addr        (pif_addr_in),
		.word_addr   (pif_addr),
		.word_data   (pif_data),
		.word_strobe (pif_wren)
	);

	word_packer #(
		.addr_t     (n64_glue_pkg::loader_addr_t),
		.swap_bytes (1'b0)
	) cart_packer (
		.clk_1x      (clk_1x),
		.rst_n       (rst_n),
		.enable      (gb_dl),
		.wr          (ioctl.wr),
		.half_sel    (ioctl.addr[1]),
		.half        (ioctl.dout),
		.addr        (gb_addr_in),
		.word_addr   (ram_addr),
		.word_data   (ram_data),
		.word_strobe (ram_req)
	);

	assign pif_wr = '{addr: pif_addr, data: pif_data, wren: pif_wren};
	assign ram_wr = '{addr: ram_addr, data: ram_data, req: ram_req};

endmodule

`default_nettype wire

// File: design/n64_glue_pkg.sv
//==================================================
// Shared constants, tables and bus structs for the
// N64 board glue logic, used by scoped name
//==================================================
`default_nettype none

package n64_glue_pkg;

	//==================================================
	// Widths and scalar types
	//==================================================
	localparam int USER_W      = 7;
	localparam int IDX_FIELD_W = 6;

	typedef logic [15:0]       half_t;
	typedef logic [31:0]       word_t;
	typedef logic [26:0]       loader_addr_t;
	typedef logic [9:0]        pif_addr_t;
	typedef logic [11:0]       ar_t;
	typedef logic [USER_W-1:0] user_t;

	// Loader index values, low six bits only
	localparam logic [IDX_FIELD_W-1:0] IDX_PIFROM   = 6'd0;
	localparam logic [IDX_FIELD_W-1:0] IDX_CART_N64 = 6'd1;
	localparam logic [IDX_FIELD_W-1:0] IDX_CART_GB  = 6'd2;

	// GB cart image sits 8 MiB into SDRAM
	localparam loader_addr_t CARTGB_START = 27'd8388608;

	//==================================================
	// Aspect ratio tables, element [n] is crop n
	//==================================================
	localparam ar_t AR_DEFAULT_X = 12'd4;
	localparam ar_t AR_DEFAULT_Y = 12'd3;

	localparam ar_t [2:0] AR_NTSC_X = '{12'd2560, 12'd1280, 12'd512};
	localparam ar_t [2:0] AR_NTSC_Y = '{12'd1714, 12'd889, 12'd381};
	localparam ar_t [2:0] AR_PAL_X  = '{12'd2048, 12'd1024, 12'd512};
	localparam ar_t [2:0] AR_PAL_Y  = '{12'd1419, 12'd731, 12'd387};

	// User-port pin per pad, pads 0..3 on pins 1, 0, 5, 4
	localparam logic [3:0][2:0] SNAC_PIN = '{3'd4, 3'd5, 3'd0, 3'd1};
	// Pins 2, 3 and 6 held high while SNAC is on
	localparam user_t SNAC_IDLE_PINS = 7'b100_1100;

	//==================================================
	// Bus structs
	//==================================================
	typedef struct packed {
		logic         download;
		logic         wr;
		loader_addr_t addr;
		half_t        dout;
		logic [7:0]   index;
	} ioctl_t;

	typedef struct packed {
		pif_addr_t addr;
		word_t     data;
		logic      wren;
	} pif_wr_t;

	typedef struct packed {
		loader_addr_t addr;
		word_t        data;
		logic         req;
	} ram_wr_t;

	typedef struct packed {
		logic       pal;
		logic       blanks_off;
		logic [1:0] crop;
		logic [1:0] ar_mode;
	} video_cfg_t;

endpackage

`default_nettype wire

// File: design/n64_glue_top.sv
//==================================================
// Board wrapper glue between loader, console core
// and user port; instances and wiring only
//==================================================
`default_nettype none

module n64_glue_top (
	input  logic                       clk_1x,
	input  logic                       rst_n,
	input  n64_glue_pkg::ioctl_t       ioctl,
	input  logic                       ram_ready,
	input  n64_glue_pkg::video_cfg_t   video_cfg,
	input  logic                       snac_en,
	input  logic [1:0]                 pad_index,
	input  logic                       pad_data_out,
	input  n64_glue_pkg::user_t        user_in,
	output logic                       ioctl_wait,
	output n64_glue_pkg::pif_wr_t      pif_wr,
	output n64_glue_pkg::ram_wr_t      ram_wr,
	output logic                       romcopy_start,
	output n64_glue_pkg::loader_addr_t romcopy_size,
	output logic                       cart_loaded,
	output logic                       cart_busy,
	output logic [12:0]                video_arx,
	output logic [12:0]                video_ary,
	output n64_glue_pkg::user_t        user_out,
	output logic                       pad_data_in
);

	// Loader downloads
	download_router download_router_inst (
		.clk_1x        (clk_1x),
		.rst_n         (rst_n),
		.ioctl         (ioctl),
		.ram_ready     (ram_ready),
		.ioctl_wait    (ioctl_wait),
		.pif_wr        (pif_wr),
		.ram_wr        (ram_wr),
		.romcopy_start (romcopy_start),
		.romcopy_size  (romcopy_size),
		.cart_loaded   (cart_loaded),
		.cart_busy     (cart_busy)
	);

	// Scaler aspect ratio
	aspect_ratio aspect_ratio_inst (
		.clk_1x    (clk_1x),
		.rst_n     (rst_n),
		.video_cfg (video_cfg),
		.video_arx (video_arx),
		.video_ary (video_ary)
	);

	// Controller on the user port
	snac_port_mux snac_port_mux_inst (
		.clk_1x       (clk_1x),
		.rst_n        (rst_n),
		.snac_en      (snac_en),
		.pad_index    (pad_index),
		.pad_data_out (pad_data_out),
		.user_in      (user_in),
		.user_out     (user_out),
		.pad_data_in  (pad_data_in)
	);

endmodule

`default_nettype wire

// File: design/snac_port_mux.sv
//==================================================
// Connects the SNAC serial line to the user-port
// pin of the selected pad
//==================================================
`default_nettype none

module snac_port_mux (
	input  logic                clk_1x,
	input  logic                rst_n,
	input  logic                snac_en,
	input  logic [1:0]          pad_index,
	input  logic                pad_data_out,
	input  n64_glue_pkg::user_t user_in,
	output n64_glue_pkg::user_t user_out,
	output logic                pad_data_in
);

	logic [2:0]          sel_pin;
	n64_glue_pkg::user_t pins_next;

	assign sel_pin = n64_glue_pkg::SNAC_PIN[pad_index];

	// Idle pins high, selected pin carries the data
	always_comb begin
		pins_next          = user_out | n64_glue_pkg::SNAC_IDLE_PINS;
		pins_next[sel_pin] = pad_data_out;
	end

	// Open-drain port, all ones releases every pin
	always_ff @(posedge clk_1x or negedge rst_n) begin
		if (!rst_n) begin
			user_out    <= '1;
			pad_data_in <= 1'b1;
		end else if (snac_en) begin
			user_out    <= pins_next;
			pad_data_in <= user_in[sel_pin];
		end else begin
			user_out <= '1;
		end
	end

endmodule

`default_nettype wire

// File: design/word_packer.sv
//==================================================
// Packs two 16-bit loader halves into one 32-bit
// word with its address, optionally byte reversed
//==================================================
`default_nettype none

module word_packer #(
	parameter type addr_t     = n64_glue_pkg::pif_addr_t,
	parameter bit  swap_bytes = 1'b0
) (
	input  logic                clk_1x,
	input  logic                rst_n,
	input  logic                enable,
	input  logic                wr,
	input  logic                half_sel,
	input  n64_glue_pkg::half_t half,
	input  addr_t               addr,
	output addr_t               word_addr,
	output n64_glue_pkg::word_t word_data,
	output logic                word_strobe
);

	logic                take;
	logic                to_upper;
	n64_glue_pkg::half_t half_in;

	assign take = enable & wr;

	// Swapped mode is big endian: first half on top, bytes exchanged
	assign to_upper = half_sel ^ swap_bytes;
	assign half_in  = swap_bytes ? {half[7:0], half[15:8]} : half;

	// Data and address
	always_ff @(posedge clk_1x) begin
		if (take) begin
			if (to_upper) begin
				word_data[31:16] <= half_in;
			end else begin
				word_data[15:0] <= half_in;
			end
			if (!half_sel) begin
				word_addr <= addr;
			end
		end
	end

	// Strobe once the second half is in
	always_ff @(posedge clk_1x or negedge rst_n) begin
		if (!rst_n) begin
			word_strobe <= 1'b0;
		end else begin
			word_strobe <= take & half_sel;
		end
	end

endmodule

`default_nettype wire

// File: n64_glue.f
design/n64_glue_pkg.sv
design/word_packer.sv
design/download_router.sv
design/aspect_ratio.sv
design/snac_port_mux.sv
design/n64_glue_top.sv
verification/n64_glue_asserts.sv
verification/n64_glue_tb.sv

// File: verification/n64_glue_asserts.sv
//==================================================
// Protocol assertions bound to the glue top level
//==================================================
`default_nettype none

module n64_glue_asserts (
	input logic                     clk_1x,
	input logic                     rst_n,
	input n64_glue_pkg::ioctl_t     ioctl,
	input logic                     ram_ready,
	input logic                     ioctl_wait,
	input n64_glue_pkg::pif_wr_t    pif_wr,
	input n64_glue_pkg::ram_wr_t    ram_wr,
	input logic                     romcopy_start,
	input logic                     snac_en,
	input n64_glue_pkg::user_t      user_out
);

	int fail_cnt = 0;

	// ROM copy start is a single-cycle pulse
	romcopy_single: assert property (@(posedge clk_1x) disable iff (!rst_n)
		romcopy_start |=> !romcopy_start)
		else begin
			fail_cnt++;
			$error("romcopy_start high for two cycles");
		end

	// Wait drops after SDRAM ready, or once the GB flag has followed download low
	wait_release: assert property (@(posedge clk_1x) disable iff (!rst_n)
		$fell(ioctl_wait) |-> ($past(ram_ready) || !$past(ioctl.download, 2)))
		else begin
			fail_cnt++;
			$error("ioctl_wait fell without ram_ready or download end");
		end

	write_exclusive: assert property (@(posedge clk_1x) disable iff (!rst_n)
		!(pif_wr.wren && ram_wr.req))
		else begin
			fail_cnt++;
			$error("boot ROM write and SDRAM request in the same cycle");
		end

	snac_release: assert property (@(posedge clk_1x) disable iff (!rst_n)
		!snac_en |=> (user_out == '1))
		else begin
			fail_cnt++;
			$error("user port not released with SNAC off");
		end

endmodule

bind n64_glue_top n64_glue_asserts n64_glue_asserts_inst (
	.clk_1x        (clk_1x),
	.rst_n         (rst_n),
	.ioctl         (ioctl),
	.ram_ready     (ram_ready),
	.ioctl_wait    (ioctl_wait),
	.pif_wr        (pif_wr),
	.ram_wr        (ram_wr),
	.romcopy_start (romcopy_start),
	.snac_en       (snac_en),
	.user_out      (user_out)
);

`default_nettype wire

// File: verification/n64_glue_tb.sv
//==================================================
// Directed testbench for the N64 board glue: loader
// downloads, aspect ratio and SNAC pin routing
//==================================================
`default_nettype none

module n64_glue_tb;

	localparam int WAIT_LIMIT = 30;

	logic                       clk_1x;
	logic                       rst_n;
	n64_glue_pkg::ioctl_t       ioctl;
	logic                       ram_ready;
	n64_glue_pkg::video_cfg_t   video_cfg;
	logic                       snac_en;
	logic [1:0]                 pad_index;
	logic                       pad_data_out;
	n64_glue_pkg::user_t        user_in;
	logic                       ioctl_wait;
	n64_glue_pkg::pif_wr_t      pif_wr;
	n64_glue_pkg::ram_wr_t      ram_wr;
	logic                       romcopy_start;
	n64_glue_pkg::loader_addr_t romcopy_size;
	logic                       cart_loaded;
	logic                       cart_busy;
	logic [12:0]                video_arx;
	logic [12:0]                video_ary;
	n64_glue_pkg::user_t        user_out;
	logic                       pad_data_in;

	int err_cnt = 0;
	int timeout_cnt = 0;
	int pif_cnt = 0;
	int ram_cnt = 0;
	int romcopy_cnt = 0;
	// Model of the core ratio register
	logic [11:0] core_x = 12'd4;
	logic [11:0] core_y = 12'd3;

	n64_glue_top n64_glue_top_inst (
		.clk_1x        (clk_1x),
		.rst_n         (rst_n),
		.ioctl         (ioctl),
		.ram_ready     (ram_ready),
		.video_cfg     (video_cfg),
		.snac_en       (snac_en),
		.pad_index     (pad_index),
		.pad_data_out  (pad_data_out),
		.user_in       (user_in),
		.ioctl_wait    (ioctl_wait),
		.pif_wr        (pif_wr),
		.ram_wr        (ram_wr),
		.romcopy_start (romcopy_start),
		.romcopy_size  (romcopy_size),
		.cart_loaded   (cart_loaded),
		.cart_busy     (cart_busy),
		.video_arx     (video_arx),
		.video_ary     (video_ary),
		.user_out      (user_out),
		.pad_data_in   (pad_data_in)
	);

	initial begin
		clk_1x = 1'b0;
		forever #20 clk_1x = ~clk_1x;
	end

	// Pulse counters for the write strobes and ROM copy start
	always @(posedge clk_1x) begin
		if (pif_wr.wren) pif_cnt++;
		if (ram_wr.req) ram_cnt++;
		if (romcopy_start) romcopy_cnt++;
	end

	//==================================================
	// Helpers
	//==================================================
	task automatic next_cycle();
		@(posedge clk_1x);
		#5;
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		assert (got === exp) else begin
			$display("CHECK FAILED: %s got 0x%0h expected 0x%0h", name, got, exp);
			err_cnt++;
		end
	endtask

	task automatic loader_write(input n64_glue_pkg::loader_addr_t a,
			input n64_glue_pkg::half_t d);
		ioctl.wr   = 1'b1;
		ioctl.addr = a;
		ioctl.dout = d;
		next_cycle();
		ioctl.wr = 1'b0;
	endtask

	task automatic hold_while_wait();
		int n;
		n = 0;
		while (ioctl_wait && n < WAIT_LIMIT) begin
			next_cycle();
			n++;
		end
		if (ioctl_wait) begin
			$display("Timeout: ioctl_wait never released the loader");
			timeout_cnt++;
		end
	endtask

	// Expected ratio per plan tables, {x, y}
	function automatic logic [23:0] table_ratio(input logic pal, input logic [1:0] crop);
		case ({pal, crop})
			3'b0_00: table_ratio = {12'd512, 12'd381};
			3'b0_01: table_ratio = {12'd1280, 12'd889};
			3'b0_10: table_ratio = {12'd2560, 12'd1714};
			3'b1_00: table_ratio = {12'd512, 12'd387};
			3'b1_01: table_ratio = {12'd1024, 12'd731};
			3'b1_10: table_ratio = {12'd2048, 12'd1419};
			default: table_ratio = {12'd4, 12'd3};
		endcase
	endfunction

	function automatic logic [2:0] pad_pin(input logic [1:0] pad);
		case (pad)
			2'd0: pad_pin = 3'd1;
			2'd1: pad_pin = 3'd0;
			2'd2: pad_pin = 3'd5;
			default: pad_pin = 3'd4;
		endcase
	endfunction

	//==================================================
	// Directed tests
	//==================================================
	task automatic reset_state_check();
		check_value("pif_wr.wren", pif_wr.wren, 1'b0);
		check_value("ram_wr.req", ram_wr.req, 1'b0);
		check_value("ioctl_wait", ioctl_wait, 1'b0);
		check_value("romcopy_start", romcopy_start, 1'b0);
		check_value("cart_loaded", cart_loaded, 1'b0);
		check_value("cart_busy", cart_busy, 1'b0);
		check_value("user_out", user_out, 7'h7f);
		check_value("video_arx", video_arx, 13'd4);
		check_value("video_ary", video_ary, 13'd3);
	endtask

	task automatic pif_rom_download(input logic [7:0] idx,
			input n64_glue_pkg::loader_addr_t base, input int words);
		int i;
		int n;
		int start_cnt;
		logic [31:0] r;
		n64_glue_pkg::loader_addr_t a;
		start_cnt = pif_cnt;
		ioctl.download = 1'b1;
		ioctl.index    = idx;
		next_cycle();
		for (i = 0; i < words; i++) begin
			a = base + 27'(i * 4);
			r = $urandom;
			// Loader bytes in order r[7:0], r[15:8], r[23:16], r[31:24]
			loader_write(a, r[15:0]);
			loader_write(a + 27'd2, r[31:16]);
			n = 0;
			while (!pif_wr.wren && n < WAIT_LIMIT) begin
				next_cycle();
				n++;
			end
			if (!pif_wr.wren) begin
				$display("Timeout: no boot ROM write for loader address 0x%0h", a);
				timeout_cnt++;
			end else begin
				check_value("pif_wr.addr", pif_wr.addr, {idx[6], a[10:2]});
				check_value("pif_wr.data", pif_wr.data, {r[7:0], r[15:8], r[23:16], r[31:24]});
			end
		end
		ioctl.download = 1'b0;
		next_cycle();
		next_cycle();
		check_value("pif write count", pif_cnt - start_cnt, words);
	endtask

	task automatic gb_cart_download(input int words);
		int i;
		int n;
		int delay;
		int start_cnt;
		logic [31:0] r;
		n64_glue_pkg::loader_addr_t base;
		n64_glue_pkg::loader_addr_t a;
		start_cnt = ram_cnt;
		base = 27'($urandom) & 27'h00ffff0;
		ioctl.download = 1'b1;
		ioctl.index    = 8'd2;
		next_cycle();
		for (i = 0; i < words; i++) begin
			a = base + 27'(i * 4);
			r = $urandom;
			hold_while_wait();
			loader_write(a, r[15:0]);
			loader_write(a + 27'd2, r[31:16]);
			n = 0;
			while (!ram_wr.req && n < WAIT_LIMIT) begin
				next_cycle();
				n++;
			end
			if (!ram_wr.req) begin
				$display("Timeout: no SDRAM request for loader address 0x%0h", a);
				timeout_cnt++;
			end else begin
				// GB image starts 8 MiB into SDRAM
				check_value("ram_wr.addr", ram_wr.addr, a + 27'h0800000);
				check_value("ram_wr.data", ram_wr.data, r);
				check_value("ioctl_wait", ioctl_wait, 1'b1);
			end
			delay = 1 + ($urandom % 6);
			repeat (delay) begin
				next_cycle();
				check_value("ioctl_wait", ioctl_wait, 1'b1);
				check_value("ram_wr.req", ram_wr.req, 1'b0);
			end
			ram_ready = 1'b1;
			next_cycle();
			ram_ready = 1'b0;
			check_value("ioctl_wait", ioctl_wait, 1'b0);
		end
		ioctl.download = 1'b0;
		next_cycle();
		next_cycle();
		check_value("ram request count", ram_cnt - start_cnt, words);
	endtask

	task automatic n64_cart_download(input int halves);
		int i;
		int n;
		int pif_start;
		int ram_start;
		int rc_start;
		n64_glue_pkg::loader_addr_t base;
		n64_glue_pkg::loader_addr_t last_addr;
		pif_start = pif_cnt;
		ram_start = ram_cnt;
		rc_start  = romcopy_cnt;
		base = 27'($urandom) & 27'h3fffff0;
		ioctl.download = 1'b1;
		ioctl.index    = 8'd1;
		next_cycle();
		check_value("cart_busy", cart_busy, 1'b1);
		for (i = 0; i < halves; i++) begin
			last_addr = base + 27'(i * 2);
			loader_write(last_addr, 16'($urandom));
			check_value("cart_busy", cart_busy, 1'b1);
		end
		check_value("cart_loaded", cart_loaded, 1'b1);
		// Address stays on the last write as download drops
		ioctl.download = 1'b0;
		n = 0;
		while (!romcopy_start && n < WAIT_LIMIT) begin
			next_cycle();
			n++;
		end
		if (!romcopy_start) begin
			$display("Timeout: ROM copy never started after the N64 download");
			timeout_cnt++;
		end else begin
			check_value("romcopy_size", romcopy_size, last_addr);
		end
		next_cycle();
		check_value("romcopy_start", romcopy_start, 1'b0);
		check_value("cart_busy", cart_busy, 1'b0);
		repeat (4) next_cycle();
		check_value("romcopy pulse count", romcopy_cnt - rc_start, 1);
		check_value("pif write count", pif_cnt - pif_start, 0);
		check_value("ram request count", ram_cnt - ram_start, 0);
		check_value("cart_loaded", cart_loaded, 1'b1);
	endtask

	task automatic set_video(input logic pal, input logic blanks, input logic [1:0] crop,
			input logic [1:0] mode);
		logic [23:0] t;
		video_cfg = '{pal: pal, blanks_off: blanks, crop: crop, ar_mode: mode};
		t = table_ratio(pal, crop);
		if (blanks) begin
			core_x = 12'd4;
			core_y = 12'd3;
		end else if (crop != 2'd3) begin
			core_x = t[23:12];
			core_y = t[11:0];
		end
		next_cycle();
		next_cycle();
		if (mode == 2'd0) begin
			check_value("video_arx", video_arx, {1'b0, core_x});
			check_value("video_ary", video_ary, {1'b0, core_y});
		end else begin
			check_value("video_arx", video_arx, 13'(mode - 2'd1));
			check_value("video_ary", video_ary, 13'd0);
		end
	endtask

	task automatic aspect_sweep();
		int p;
		int c;
		int m;
		for (p = 0; p < 2; p++) begin
			for (c = 0; c < 3; c++) begin
				set_video(p[0], 1'b0, c[1:0], 2'd0);
			end
		end
		// Crop 3 keeps the last ratio
		set_video(1'b1, 1'b0, 2'd3, 2'd0);
		for (m = 1; m < 4; m++) begin
			set_video(1'b0, 1'b0, 2'd1, m[1:0]);
		end
		set_video(1'b0, 1'b1, 2'd1, 2'd0);
		set_video(1'b1, 1'b0, 2'd0, 2'd0);
	endtask

	task automatic snac_routing();
		int p;
		int k;
		logic [2:0] pin;
		logic d;
		n64_glue_pkg::user_t ui;
		n64_glue_pkg::user_t exp_user;
		exp_user = 7'h7f;
		snac_en  = 1'b1;
		for (p = 0; p < 4; p++) begin
			pin = pad_pin(p[1:0]);
			for (k = 0; k < 2; k++) begin
				d  = (k == 0);
				ui = 7'($urandom);
				pad_index    = p[1:0];
				pad_data_out = d;
				user_in      = ui;
				next_cycle();
				// Idle pins 2, 3, 6 high, other pads keep their last level
				exp_user      = exp_user | 7'b100_1100;
				exp_user[pin] = d;
				check_value("user_out", user_out, exp_user);
				check_value("pad_data_in", pad_data_in, ui[pin]);
			end
		end
		snac_en = 1'b0;
		next_cycle();
		check_value("user_out", user_out, 7'h7f);
	endtask

	//==================================================
	// Main sequence
	//==================================================
	initial begin
		void'($urandom(32'h1f8e075a));
		rst_n        = 1'b0;
		ioctl        = '0;
		ram_ready    = 1'b0;
		video_cfg    = '0;
		snac_en      = 1'b0;
		pad_index    = 2'd0;
		pad_data_out = 1'b1;
		user_in      = '1;
		repeat (8) @(posedge clk_1x);
		#5;
		reset_state_check();
		rst_n = 1'b1;
		next_cycle();
		pif_rom_download(8'h00, 27'h0000000, 4);
		pif_rom_download(8'h40, 27'h00007f0, 4);
		gb_cart_download(6);
		n64_cart_download(10);
		aspect_sweep();
		snac_routing();
		check_value("cart_loaded", cart_loaded, 1'b1);
		$display("Check failures: %0d, timeouts: %0d, assertion failures: %0d",
			err_cnt, timeout_cnt, n64_glue_top_inst.n64_glue_asserts_inst.fail_cnt);
		if (err_cnt == 0 && timeout_cnt == 0
				&& n64_glue_top_inst.n64_glue_asserts_inst.fail_cnt == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
